// File: common/procPkg.sv
//######################################################################
// Processor package: word types, opcode and ALU encodings, field layout
//######################################################################
package procPkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  addr_t;
    typedef logic [2:0]  regIdx_t;

    // Memory depth follows the 8-bit address, register count the 3-bit index
    localparam int memWords = 256;
    localparam int numRegs  = 8;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluXor,
        aluAndn,
        aluPassB
    } aluOp_t;

    // Any opcode not listed here traps as illegal
    typedef enum logic [4:0] {
        opHalt = 5'b00000,
        opJ    = 5'b00100,
        opAddi = 5'b01000,
        opSubi = 5'b01001,
        opXori = 5'b01010,
        opBeqz = 5'b01100,
        opBnez = 5'b01101,
        opSt   = 5'b10000,
        opLd   = 5'b10001,
        opLbi  = 5'b11000,
        opAlu  = 5'b11011
    } opcode_t;

    // Instruction field positions
    localparam int opcMsb   = 15;
    localparam int opcLsb   = 11;
    localparam int rsMsb    = 10;
    localparam int rsLsb    = 8;
    localparam int rtMsb    = 7;
    localparam int rtLsb    = 5;
    localparam int rdMsb    = 4;
    localparam int rdLsb    = 2;
    localparam int functMsb = 1;
    localparam int functLsb = 0;
    localparam int imm5Msb  = 4;
    localparam int imm8Msb  = 7;
    localparam int immLsb   = 0;

endpackage

// File: common/ctrlIf.sv
//######################################################################
// Decoded control signals from the opcode decoder to the stages
//######################################################################
`timescale 1ns/1ps

interface ctrlIf;
    import procPkg::*;

    logic   regWrite;
    logic   wrSelRt;
    logic   immSel;
    logic   immSigned;
    logic   aluSrcImm;
    aluOp_t aluOp;
    logic   memRead;
    logic   memWrite;
    logic   memToReg;
    logic   branch;
    logic   branchNz;
    logic   jump;
    logic   halt;

    modport control (
        output regWrite, wrSelRt, immSel, immSigned, aluSrcImm, aluOp,
        output memRead, memWrite, memToReg, branch, branchNz, jump, halt
    );
    modport decode   (input regWrite, wrSelRt, immSel, immSigned);
    modport execute  (input aluSrcImm, aluOp, branch, branchNz, jump);
    modport memStage (input memRead, memWrite, memToReg);
    modport fetch    (input halt);

endinterface

// File: design/control.sv
//######################################################################
// Opcode decoder, drives stage controls and flags illegal opcodes
//######################################################################
`timescale 1ns/1ps

module control (
    input  procPkg::word_t instr,
    output logic           err,
    ctrlIf.control         ctrl
);
    import procPkg::*;

    opcode_t    opcode;
    logic [1:0] funct;

    assign opcode = opcode_t'(instr[opcMsb:opcLsb]);
    assign funct  = instr[functMsb:functLsb];

    always_comb begin
        ctrl.regWrite  = 1'b0;
        ctrl.wrSelRt   = 1'b0;
        ctrl.immSel    = 1'b0;
        ctrl.immSigned = 1'b1;
        ctrl.aluSrcImm = 1'b0;
        ctrl.aluOp     = aluAdd;
        ctrl.memRead   = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.memToReg  = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.branchNz  = 1'b0;
        ctrl.jump      = 1'b0;
        ctrl.halt      = 1'b0;
        err            = 1'b0;
        case (opcode)
            opAlu: begin
                ctrl.regWrite = 1'b1;
                case (funct)
                    2'b00:   ctrl.aluOp = aluAdd;
                    2'b01:   ctrl.aluOp = aluSub;
                    2'b10:   ctrl.aluOp = aluXor;
                    default: ctrl.aluOp = aluAndn;
                endcase
            end
            opAddi, opSubi, opXori: begin
                ctrl.regWrite  = 1'b1;
                ctrl.wrSelRt   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = (opcode == opAddi) ? aluAdd :
                                 (opcode == opSubi) ? aluSub : aluXor;
            end
            opLbi: begin
                // 8-bit immediate with a write means the destination is rs
                ctrl.regWrite  = 1'b1;
                ctrl.immSel    = 1'b1;
                ctrl.immSigned = 1'b0;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluPassB;
            end
            opLd: begin
                ctrl.regWrite  = 1'b1;
                ctrl.wrSelRt   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
            end
            opSt: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
            end
            opBeqz, opBnez: begin
                ctrl.immSel   = 1'b1;
                ctrl.branch   = 1'b1;
                ctrl.branchNz = (opcode == opBnez);
            end
            opJ: begin
                ctrl.immSel = 1'b1;
                ctrl.jump   = 1'b1;
            end
            opHalt: ctrl.halt = 1'b1;
            default: begin
                // Illegal opcode stops the core as well
                ctrl.halt = 1'b1;
                err       = 1'b1;
            end
        endcase
    end

endmodule

// File: fetch/fetch.sv
//######################################################################
// Program counter, instruction memory with load port, halt/err latches
//######################################################################
`timescale 1ns/1ps

module fetch (
    input  logic           clk,
    input  logic           arstN,
    input  logic           loadEn,
    input  procPkg::addr_t loadAddr,
    input  procPkg::word_t loadData,
    input  procPkg::word_t nextPc,
    ctrlIf.fetch           ctrl,
    input  logic           illegal,
    output procPkg::word_t pc,
    output procPkg::word_t instr,
    output logic           halted,
    output logic           err
);
    import procPkg::*;

    word_t imem [memWords];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            imem[loadAddr] <= loadData;
        end
    end

    // A halt word is presented while reset holds, so no stage writes
    assign instr = arstN ? imem[addr_t'(pc)] : {opHalt, 11'd0};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc     <= '0;
            halted <= 1'b0;
            err    <= 1'b0;
        end else if (!halted) begin
            pc     <= nextPc;
            halted <= ctrl.halt;
            err    <= illegal;
        end
    end

endmodule

// File: decode/decode.sv
//######################################################################
// Register file, destination select and immediate extension
//######################################################################
`timescale 1ns/1ps

module decode (
    input  logic            clk,
    input  logic            arstN,
    input  procPkg::word_t  instr,
    input  procPkg::word_t  wrData,
    input  logic            halted,
    ctrlIf.decode           ctrl,
    output procPkg::word_t  rsData,
    output procPkg::word_t  rtData,
    output procPkg::word_t  imm,
    output procPkg::regIdx_t wrIdx,
    output logic            wrEn
);
    import procPkg::*;

    word_t      regFile [numRegs];
    regIdx_t    rsIdx;
    regIdx_t    rtIdx;
    regIdx_t    rdIdx;
    logic [4:0] imm5;
    logic [7:0] imm8;

    assign rsIdx = instr[rsMsb:rsLsb];
    assign rtIdx = instr[rtMsb:rtLsb];
    assign rdIdx = instr[rdMsb:rdLsb];
    assign imm5  = instr[imm5Msb:immLsb];
    assign imm8  = instr[imm8Msb:immLsb];

    assign rsData = regFile[rsIdx];
    assign rtData = regFile[rtIdx];

    // Only LBI writes with the 8-bit immediate, and it targets rs
    assign wrIdx = ctrl.immSel  ? rsIdx :
                   ctrl.wrSelRt ? rtIdx : rdIdx;
    assign wrEn  = ctrl.regWrite && !halted;

    always_comb begin
        if (ctrl.immSel) begin
            imm = ctrl.immSigned ? {{8{imm8[7]}}, imm8} : {8'd0, imm8};
        end else begin
            imm = ctrl.immSigned ? {{11{imm5[4]}}, imm5} : {11'd0, imm5};
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regFile[i] <= '0;
            end
        end else if (wrEn) begin
            regFile[wrIdx] <= wrData;
        end
    end

endmodule

// File: execute/execute.sv
//######################################################################
// ALU, zero-test branch decision and next PC selection
//######################################################################
`timescale 1ns/1ps

module execute (
    input  procPkg::word_t pc,
    input  procPkg::word_t rsData,
    input  procPkg::word_t rtData,
    input  procPkg::word_t imm,
    ctrlIf.execute         ctrl,
    output procPkg::word_t aluResult,
    output procPkg::word_t nextPc
);
    import procPkg::*;

    word_t opB;
    word_t pcPlus1;
    logic  rsZero;
    logic  taken;

    assign opB = ctrl.aluSrcImm ? imm : rtData;

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:   aluResult = rsData + opB;
            aluSub:   aluResult = rsData - opB;
            aluXor:   aluResult = rsData ^ opB;
            aluAndn:  aluResult = rsData & ~opB;
            default:  aluResult = opB;
        endcase
    end

    assign rsZero  = (rsData == '0);
    assign taken   = ctrl.jump ||
                     (ctrl.branch && (ctrl.branchNz ? !rsZero : rsZero));

    // Targets are relative to the following instruction
    assign pcPlus1 = pc + word_t'(1);
    assign nextPc  = taken ? pcPlus1 + imm : pcPlus1;

endmodule

// File: design/memStage.sv
//######################################################################
// Data memory and writeback data selection
//######################################################################
`timescale 1ns/1ps

module memStage (
    input  logic           clk,
    input  logic           halted,
    input  procPkg::word_t aluResult,
    input  procPkg::word_t rtData,
    ctrlIf.memStage        ctrl,
    output procPkg::word_t wrData,
    output logic           memWrEn
);
    import procPkg::*;

    word_t dmem [memWords];
    addr_t addr;
    word_t readData;

    // Word address from the low byte of the effective address
    assign addr    = addr_t'(aluResult);
    assign memWrEn = ctrl.memWrite && !halted;

    always_ff @(posedge clk) begin
        if (memWrEn) begin
            dmem[addr] <= rtData;
        end
    end

    assign readData = ctrl.memRead ? dmem[addr] : '0;
    assign wrData   = ctrl.memToReg ? readData : aluResult;

endmodule

// File: design/proc.sv
//######################################################################
// Single-cycle 16-bit processor top, wires the four stages together
//######################################################################
`timescale 1ns/1ps

module proc (
    input  logic             clk,
    input  logic             arstN,
    input  logic             loadEn,
    input  procPkg::addr_t   loadAddr,
    input  procPkg::word_t   loadData,
    output logic             err,
    output logic             halted,
    output procPkg::word_t   pc,
    output logic             regWrEn,
    output procPkg::regIdx_t regWrIdx,
    output procPkg::word_t   regWrData,
    output logic             memWrEn,
    output procPkg::addr_t   memWrAddr,
    output procPkg::word_t   memWrData
);
    import procPkg::*;

    ctrlIf ctrl ();

    word_t instr;
    word_t nextPc;
    word_t rsData;
    word_t rtData;
    word_t imm;
    word_t aluResult;
    word_t wrData;
    logic  illegal;

    control control0 (.instr(instr), .err(illegal), .ctrl(ctrl.control));

    fetch fetch0 (
        .clk(clk), .arstN(arstN), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .nextPc(nextPc), .ctrl(ctrl.fetch),
        .illegal(illegal), .pc(pc), .instr(instr), .halted(halted), .err(err)
    );

    decode decode0 (
        .clk(clk), .arstN(arstN), .instr(instr), .wrData(wrData),
        .halted(halted), .ctrl(ctrl.decode), .rsData(rsData), .rtData(rtData),
        .imm(imm), .wrIdx(regWrIdx), .wrEn(regWrEn)
    );

    execute execute0 (
        .pc(pc), .rsData(rsData), .rtData(rtData), .imm(imm),
        .ctrl(ctrl.execute), .aluResult(aluResult), .nextPc(nextPc)
    );

    memStage memStage0 (
        .clk(clk), .halted(halted), .aluResult(aluResult), .rtData(rtData),
        .ctrl(ctrl.memStage), .wrData(wrData), .memWrEn(memWrEn)
    );

    // Trace of the retiring write
    assign regWrData = wrData;
    assign memWrAddr = addr_t'(aluResult);
    assign memWrData = rtData;

endmodule

// File: tests/proc_props.sv
//######################################################################
// Bound checks on trace gating, halt hold and sticky error
//######################################################################
`timescale 1ns/1ps

module procProps (
    input logic           clk,
    input logic           arstN,
    input logic           err,
    input logic           halted,
    input procPkg::word_t pc,
    input logic           regWrEn,
    input logic           memWrEn
);

    noWriteInReset: assert property (@(posedge clk) !arstN |-> !regWrEn && !memWrEn)
        else $error("trace enable active during reset");

    noWriteHalted: assert property (@(posedge clk) disable iff (!arstN)
        halted |-> !regWrEn && !memWrEn)
        else $error("trace enable active while halted");

    // Halted core keeps its program counter
    pcHeld: assert property (@(posedge clk) disable iff (!arstN) halted |=> $stable(pc))
        else $error("pc moved while halted");

    errSticky: assert property (@(posedge clk) disable iff (!arstN) !$fell(err))
        else $error("err dropped without a reset");

endmodule

bind proc procProps procPropsInst (
    .clk(clk), .arstN(arstN), .err(err), .halted(halted), .pc(pc),
    .regWrEn(regWrEn), .memWrEn(memWrEn)
);

// File: tests/procTb.sv
//######################################################################
// Testbench for the single-cycle processor against an instruction-set model
//######################################################################
`timescale 1ns/1ps

module procTb;
    import procPkg::*;

    localparam int timeoutCycles = 2000;
    localparam int haltHoldCycles = 20;

    logic    clk;
    logic    arstN;
    logic    loadEn;
    addr_t   loadAddr;
    word_t   loadData;
    logic    err;
    logic    halted;
    word_t   pc;
    logic    regWrEn;
    regIdx_t regWrIdx;
    word_t   regWrData;
    logic    memWrEn;
    addr_t   memWrAddr;
    word_t   memWrData;

    // Program image and model state
    // Model data memory persists across runs like the DUT's
    word_t prog [memWords];
    int    progLen;
    word_t mReg [numRegs];
    word_t mMem [memWords];
    word_t mPc;
    int    valueErrs = 0;
    int    timeoutErrs = 0;

    proc proc_inst (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
            valueErrs++;
        end
    endtask

    task automatic checkIdx(input string name, input regIdx_t got, input regIdx_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
            valueErrs++;
        end
    endtask

    task automatic checkAddr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
            valueErrs++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
            valueErrs++;
        end
    endtask

    function automatic int randBelow(int n);
        return int'($urandom % n);
    endfunction

    function automatic word_t encReg(opcode_t op, int rs, int rt, int rd, int fn);
        return {op, 3'(rs), 3'(rt), 3'(rd), 2'(fn)};
    endfunction

    function automatic word_t encImm5(opcode_t op, int rs, int rt, int imm);
        return {op, 3'(rs), 3'(rt), 5'(imm)};
    endfunction

    function automatic word_t encImm8(opcode_t op, int rs, int imm);
        return {op, 3'(rs), 8'(imm)};
    endfunction

    function automatic logic isLegal(logic [4:0] opc);
        return opc inside {opHalt, opJ, opAddi, opSubi, opXori, opBeqz, opBnez,
                           opSt, opLd, opLbi, opAlu};
    endfunction

    // r7 is a fixed data base pointer, so writes go only to r0..r6
    function automatic word_t randInstr(int idx, int lastIdx);
        int    span;
        word_t w;
        span = lastIdx - idx - 1;
        if (span > 7) begin
            span = 7;
        end
        case (randBelow(16))
            4, 5: w = encReg(opAlu, randBelow(8), randBelow(8), randBelow(7), randBelow(4));
            6: w = encImm5(opAddi, randBelow(8), randBelow(7), randBelow(32));
            7: w = encImm5(opSubi, randBelow(8), randBelow(7), randBelow(32));
            8: w = encImm5(opXori, randBelow(8), randBelow(7), randBelow(32));
            9: w = encImm5(opLd, 7, randBelow(7), randBelow(8));
            10, 11: w = encImm5(opSt, 7, randBelow(8), randBelow(8));
            12: w = encImm8(opBeqz, randBelow(8), randBelow(span + 1));
            13: w = encImm8(opBnez, randBelow(8), randBelow(span + 1));
            14: w = encImm8(opJ, 0, randBelow(span + 1));
            default: w = encImm8(opLbi, randBelow(7), randBelow(256));
        endcase
        return w;
    endfunction

    task automatic buildMain();
        progLen = 121;
        // No-op branch first, then fill the data window the loads read
        prog[0] = encImm8(opBeqz, 0, 0);
        prog[1] = encImm8(opLbi, 7, 8'h40);
        for (int i = 0; i < 8; i++) begin
            prog[2 + i] = encImm5(opSt, 7, i, i);
        end
        // Path 10 to 12 to 11 to 14 takes a negative branch offset
        prog[10] = encImm8(opJ, 0, 1);
        prog[11] = encImm8(opJ, 0, 2);
        prog[12] = encImm8(opBeqz, 0, -2);
        for (int i = 13; i < 120; i++) begin
            prog[i] = randInstr(i, 120);
        end
        prog[120] = encImm8(opHalt, 0, 0);
    endtask

    task automatic buildIllegal();
        logic [4:0] opc;
        progLen = 16;
        prog[0] = encImm8(opLbi, 7, 8'h40);
        for (int i = 1; i < 8; i++) begin
            prog[i] = randInstr(i, 8);
        end
        do begin
            opc = 5'(randBelow(32));
        end while (isLegal(opc));
        prog[8] = {opc, 11'(randBelow(2048))};
        for (int i = 9; i < 15; i++) begin
            prog[i] = randInstr(i, 15);
        end
        prog[15] = encImm8(opHalt, 0, 0);
    endtask

    // Predict the trace of the instruction at mPc, then commit it
    task automatic retire(output logic stop);
        word_t   ins;
        regIdx_t rs;
        regIdx_t rt;
        word_t   a;
        word_t   b;
        word_t   s5;
        word_t   s8;
        addr_t   ea;
        logic    wEn;
        regIdx_t wIdx;
        word_t   wData;
        logic    sEn;
        word_t   tgt;
        ins   = prog[addr_t'(mPc)];
        rs    = ins[10:8];
        rt    = ins[7:5];
        a     = mReg[rs];
        b     = mReg[rt];
        s5    = {{11{ins[4]}}, ins[4:0]};
        s8    = {{8{ins[7]}}, ins[7:0]};
        ea    = addr_t'(a + s5);
        wEn   = 1'b1;
        wIdx  = rt;
        wData = '0;
        sEn   = 1'b0;
        stop  = 1'b0;
        tgt   = mPc + word_t'(1);
        case (ins[15:11])
            opAlu: begin
                wIdx = ins[4:2];
                case (ins[1:0])
                    2'b00:   wData = a + b;
                    2'b01:   wData = a - b;
                    2'b10:   wData = a ^ b;
                    default: wData = a & ~b;
                endcase
            end
            opAddi: wData = a + s5;
            opSubi: wData = a - s5;
            opXori: wData = a ^ s5;
            opLbi: begin
                wIdx  = rs;
                wData = {8'd0, ins[7:0]};
            end
            opLd: wData = mMem[ea];
            opSt: begin
                wEn = 1'b0;
                sEn = 1'b1;
            end
            opBeqz, opBnez: begin
                wEn = 1'b0;
                if ((a == '0) == (ins[15:11] == opBeqz)) begin
                    tgt = tgt + s8;
                end
            end
            opJ: begin
                wEn = 1'b0;
                tgt = tgt + s8;
            end
            default: begin
                // Halt and illegal opcodes
                wEn  = 1'b0;
                stop = 1'b1;
            end
        endcase
        checkBit("regWrEn", regWrEn, wEn);
        checkBit("memWrEn", memWrEn, sEn);
        if (wEn) begin
            checkIdx("regWrIdx", regWrIdx, wIdx);
            checkWord("regWrData", regWrData, wData);
            mReg[wIdx] = wData;
        end
        if (sEn) begin
            checkAddr("memWrAddr", memWrAddr, ea);
            checkWord("memWrData", memWrData, b);
            mMem[ea] = b;
        end
        mPc = tgt;
    endtask

    task automatic checkHalted(input logic expErr);
        int cycles;
        cycles = 0;
        while (halted !== 1'b1 && cycles < timeoutCycles) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("Timeout: halted never rose after the halting instruction");
            timeoutErrs++;
        end else begin
            for (int c = 0; c < haltHoldCycles; c++) begin
                checkWord("pc", pc, mPc);
                checkBit("halted", halted, 1'b1);
                checkBit("err", err, expErr);
                checkBit("regWrEn", regWrEn, 1'b0);
                checkBit("memWrEn", memWrEn, 1'b0);
                @(negedge clk);
            end
        end
    endtask

    task automatic runProgram(input logic expErr);
        logic done;
        int   cycles;
        @(posedge clk);
        arstN <= 1'b0;
        for (int a = 0; a < progLen; a++) begin
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= addr_t'(a);
            loadData <= prog[a];
        end
        @(posedge clk);
        loadEn <= 1'b0;
        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            checkWord("pc", pc, 16'h0);
            checkBit("halted", halted, 1'b0);
            checkBit("err", err, 1'b0);
            checkBit("regWrEn", regWrEn, 1'b0);
            checkBit("memWrEn", memWrEn, 1'b0);
            @(posedge clk);
        end
        arstN <= 1'b1;
        for (int r = 0; r < numRegs; r++) begin
            mReg[r] = '0;
        end
        mPc    = '0;
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < timeoutCycles) begin
            @(negedge clk);
            checkWord("pc", pc, mPc);
            checkBit("halted", halted, 1'b0);
            checkBit("err", err, 1'b0);
            retire(done);
            cycles++;
        end
        if (!done) begin
            $display("Timeout: program did not reach its halting instruction");
            timeoutErrs++;
        end else begin
            checkHalted(expErr);
        end
    endtask

    initial begin
        arstN    = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        void'($urandom(32'h6616fe0f));
        buildMain();
        runProgram(1'b0);
        if (timeoutErrs == 0) begin
            buildIllegal();
            runProgram(1'b1);
        end
        $display("Errors: value mismatches %0d, timeouts %0d", valueErrs, timeoutErrs);
        if (valueErrs == 0 && timeoutErrs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
common/procPkg.sv
common/ctrlIf.sv
design/control.sv
fetch/fetch.sv
decode/decode.sv
execute/execute.sv
design/memStage.sv
design/proc.sv
tests/proc_props.sv
tests/procTb.sv

// File: Makefile
# Verilator flow for the processor testbench

VERILATOR ?= verilator
TOP       ?= procTb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= test failed
PASS_MSG  ?= test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJDIR) -o V$(TOP)

# The log decides the result, the fail message is searched first
sim: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
